// ==== verilog/ciPkg.sv ====
package ciPkg;

  localparam int ciDataWidth = 32;
  localparam int ciIdWidth = 8;

  // stretcher counter whose top bit marks release
  localparam int resetCountWidth = 5;

  // instruction numbers
  localparam logic [ciIdWidth-1:0] swapByteId = 8'd1;
  localparam logic [ciIdWidth-1:0] cycleCountId = 8'd4;
  localparam logic [ciIdWidth-1:0] grayscaleId = 8'd9;

  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565Pixel;

  // one operand word seen as bytes or as two pixels
  typedef union packed {
    logic [ciDataWidth/8-1:0][7:0] bytes;
    struct packed {
      rgb565Pixel upper;
      rgb565Pixel lower;
    } pixels;
  } ciOperand;

endpackage

// ==== verilog/ciRequestIf.sv ====
interface ciRequestIf;

  logic valid;
  logic selSwap;
  logic selCycle;
  logic selGray;
  ciPkg::ciOperand operandA;
  logic [ciPkg::ciDataWidth-1:0] operandB;

  modport source (
    output valid, selSwap, selCycle, selGray, operandA, operandB
  );

  // selects only mean something while valid is high
  modport sink (
    input valid, selSwap, selCycle, selGray, operandA, operandB
  );

endinterface

// ==== verilog/ciRequestStage.sv ====
module ciRequestStage (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  input  logic                          ciStart,
  input  logic [ciPkg::ciIdWidth-1:0]   ciN,
  input  logic [ciPkg::ciDataWidth-1:0] ciDataA,
  input  logic [ciPkg::ciDataWidth-1:0] ciDataB,
  output logic                          unitReset,
  ciRequestIf.source                    request
);

  logic [ciPkg::resetCountWidth-1:0] resetCountReg;
  logic startAccepted;

  // counts up after lock and stops once the top bit is set
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCountReg <= '0;
    end else if (!resetCountReg[ciPkg::resetCountWidth-1]) begin
      resetCountReg <= resetCountReg + 1'b1;
    end
  end

  assign unitReset = ~resetCountReg[ciPkg::resetCountWidth-1];

  // starts while in reset are dropped
  assign startAccepted = ciStart & ~unitReset;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      request.valid    <= 1'b0;
      request.selSwap  <= 1'b0;
      request.selCycle <= 1'b0;
      request.selGray  <= 1'b0;
    end else begin
      request.valid    <= startAccepted;
      request.selSwap  <= startAccepted & (ciN == ciPkg::swapByteId);
      request.selCycle <= startAccepted & (ciN == ciPkg::cycleCountId);
      request.selGray  <= startAccepted & (ciN == ciPkg::grayscaleId);
    end
  end

  // operands follow the accepted start
  always_ff @(posedge s_systemClock) begin
    if (startAccepted) begin
      request.operandA <= ciDataA;
      request.operandB <= ciDataB;
    end
  end

endmodule

// ==== verilog/pixelFormatIse.sv ====
module pixelFormatIse (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  ciRequestIf.sink                      request,
  output logic                          done,
  output logic [ciPkg::ciDataWidth-1:0] result
);

  ciPkg::rgb565Pixel lowerPixel;
  logic [7:0] red8;
  logic [7:0] green8;
  logic [7:0] blue8;
  logic [15:0] graySum;
  logic [ciPkg::ciDataWidth-1:0] swapValue;
  logic [ciPkg::ciDataWidth-1:0] grayValue;
  logic swapHit;
  logic grayHit;

  assign swapHit = request.valid & request.selSwap;
  assign grayHit = request.valid & request.selGray;

  // byte view of operand A
  assign swapValue = {
    request.operandA.bytes[0],
    request.operandA.bytes[1],
    request.operandA.bytes[2],
    request.operandA.bytes[3]
  };

  // pixel view of the same word
  assign lowerPixel = request.operandA.pixels.lower;
  assign red8 = {lowerPixel.red, 3'b000};
  assign green8 = {lowerPixel.green, 2'b00};
  assign blue8 = {lowerPixel.blue, 3'b000};

  // weights sum to 256, so the gray byte is the upper half
  assign graySum = red8 * 8'd54 + green8 * 8'd183 + blue8 * 8'd19;
  assign grayValue = {{(ciPkg::ciDataWidth - 8){1'b0}}, graySum[15:8]};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done <= swapHit | grayHit;
      if (swapHit) begin
        result <= swapValue;
      end else if (grayHit) begin
        result <= grayValue;
      end else begin
        // zero when idle so the merge can OR all results
        result <= '0;
      end
    end
  end

endmodule

// ==== verilog/cycleCounterIse.sv ====
module cycleCounterIse (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  ciRequestIf.sink                      request,
  input  logic                          unitReset,
  output logic                          done,
  output logic [ciPkg::ciDataWidth-1:0] result
);

  logic [ciPkg::ciDataWidth-1:0] cycleCount;
  logic countHit;

  assign countHit = request.valid & request.selCycle;

  // free running once the unit leaves reset
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      cycleCount <= '0;
    end else if (unitReset) begin
      cycleCount <= '0;
    end else begin
      cycleCount <= cycleCount + 1'b1;
    end
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      done   <= 1'b0;
      result <= '0;
    end else begin
      done   <= countHit;
      result <= countHit ? cycleCount : '0;
    end
  end

endmodule

// ==== verilog/ciResultMerge.sv ====
module ciResultMerge (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  input  logic                          pixelDone,
  input  logic [ciPkg::ciDataWidth-1:0] pixelResult,
  input  logic                          cycleDone,
  input  logic [ciPkg::ciDataWidth-1:0] cycleResult,
  output logic                          ciDone,
  output logic [ciPkg::ciDataWidth-1:0] ciResult
);

  logic mergedDone;
  logic [ciPkg::ciDataWidth-1:0] mergedResult;

  // every block drives zero unless it answers, so a plain OR is enough
  assign mergedDone = pixelDone | cycleDone;
  assign mergedResult = pixelResult | cycleResult;

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      ciDone   <= 1'b0;
      ciResult <= '0;
    end else begin
      ciDone   <= mergedDone;
      ciResult <= mergedResult;
    end
  end

endmodule

// ==== verilog/customInstructionUnit.sv ====
module customInstructionUnit (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  input  logic                          ciStart,
  input  logic [ciPkg::ciIdWidth-1:0]   ciN,
  input  logic [ciPkg::ciDataWidth-1:0] ciDataA,
  input  logic [ciPkg::ciDataWidth-1:0] ciDataB,
  output logic                          ciDone,
  output logic [ciPkg::ciDataWidth-1:0] ciResult,
  output logic                          unitReset
);

  logic pixelDone;
  logic [ciPkg::ciDataWidth-1:0] pixelResult;
  logic cycleDone;
  logic [ciPkg::ciDataWidth-1:0] cycleResult;

  ciRequestIf ciRequestIf_inst ();

  ciRequestStage ciRequestStage_inst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .unitReset     (unitReset),
    .request       (ciRequestIf_inst.source)
  );

  pixelFormatIse pixelFormatIse_inst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .request       (ciRequestIf_inst.sink),
    .done          (pixelDone),
    .result        (pixelResult)
  );

  cycleCounterIse cycleCounterIse_inst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .request       (ciRequestIf_inst.sink),
    .unitReset     (unitReset),
    .done          (cycleDone),
    .result        (cycleResult)
  );

  ciResultMerge ciResultMerge_inst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .pixelDone     (pixelDone),
    .pixelResult   (pixelResult),
    .cycleDone     (cycleDone),
    .cycleResult   (cycleResult),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

endmodule

// ==== verif/ciUnit_sva.sv ====
module ciUnitSva (
  input logic                          s_systemClock,
  input logic                          s_pllLocked,
  input logic                          ciStart,
  input logic [ciPkg::ciIdWidth-1:0]   ciN,
  input logic [ciPkg::ciDataWidth-1:0] ciDataA,
  input logic                          ciDone,
  input logic [ciPkg::ciDataWidth-1:0] ciResult,
  input logic                          unitReset
);

  timeunit 1ns;
  timeprecision 100ps;

  logic failSeen = 1'b0;
  logic [31:0] dataADelay1;
  logic [31:0] dataADelay2;
  logic [31:0] dataADelay3;
  logic [31:0] previousResult;
  logic [31:0] expectedSwap;
  logic [31:0] expectedGray;
  logic acceptedStart;
  logic claimedId;

  function automatic logic [31:0] reverseBytes(input logic [31:0] word);
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  // luma weights 54, 183, 19 out of 256
  function automatic logic [31:0] grayOfLowerPixel(input logic [31:0] word);
    logic [31:0] weighted;
    weighted = 54 * {word[15:11], 3'b000} + 183 * {word[10:5], 2'b00}
             + 19 * {word[4:0], 3'b000};
    return {24'h0, weighted[15:8]};
  endfunction

  // operand A as it was three edges ago
  always_ff @(posedge s_systemClock) begin
    dataADelay1 <= ciDataA;
    dataADelay2 <= dataADelay1;
    dataADelay3 <= dataADelay2;
    previousResult <= ciResult;
  end

  assign expectedSwap = reverseBytes(dataADelay3);
  assign expectedGray = grayOfLowerPixel(dataADelay3);
  assign acceptedStart = ciStart && !unitReset;
  assign claimedId = (ciN == ciPkg::swapByteId) || (ciN == ciPkg::cycleCountId)
                   || (ciN == ciPkg::grayscaleId);

  assert property (@(posedge s_systemClock) !s_pllLocked |=> unitReset)
    else begin
      $error("unitReset was low although s_pllLocked was low");
      failSeen = 1'b1;
    end

  assert property (@(posedge s_systemClock)
    $rose(s_pllLocked) |-> unitReset [*16] ##1 !unitReset)
    else begin
      $error("unitReset did not stay high for exactly 16 cycles after lock");
      failSeen = 1'b1;
    end

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    unitReset |-> !ciDone)
    else begin
      $error("ciDone went high while the unit was in reset");
      failSeen = 1'b1;
    end

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    acceptedStart && ciN == ciPkg::swapByteId |-> ##3 (ciDone && ciResult == expectedSwap))
    else begin
      $error("** Error swapByteResult: expected %h, actual %h, ciDone %b",
        $sampled(expectedSwap), $sampled(ciResult), $sampled(ciDone));
      failSeen = 1'b1;
    end

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    acceptedStart && ciN == ciPkg::grayscaleId |-> ##3 (ciDone && ciResult == expectedGray))
    else begin
      $error("** Error grayscaleResult: expected %h, actual %h, ciDone %b",
        $sampled(expectedGray), $sampled(ciResult), $sampled(ciDone));
      failSeen = 1'b1;
    end

  // second read of a back-to-back pair sees the next count
  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    acceptedStart && ciN == ciPkg::cycleCountId ##1 acceptedStart && ciN == ciPkg::cycleCountId
    |-> ##2 ciDone ##1 (ciDone && ciResult == previousResult + 1))
    else begin
      $error("** Error cycleCountStep: expected %h, actual %h, ciDone %b",
        $sampled(previousResult) + 1, $sampled(ciResult), $sampled(ciDone));
      failSeen = 1'b1;
    end

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    acceptedStart && !claimedId |-> ##3 !ciDone)
    else begin
      $error("ciDone answered an instruction number that no block claims");
      failSeen = 1'b1;
    end

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked)
    !ciDone |-> ciResult == '0)
    else begin
      $error("** Error idleResultZero: expected %h, actual %h", 32'h0, $sampled(ciResult));
      failSeen = 1'b1;
    end

endmodule

bind customInstructionUnit ciUnitSva ciUnitSva_inst (
  .s_systemClock (s_systemClock),
  .s_pllLocked   (s_pllLocked),
  .ciStart       (ciStart),
  .ciN           (ciN),
  .ciDataA       (ciDataA),
  .ciDone        (ciDone),
  .ciResult      (ciResult),
  .unitReset     (unitReset)
);

// ==== verif/ciUnitTb.sv ====
module ciUnitTb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int clockHalfPeriod = 20;
  localparam int driveDelay = 2;
  localparam int lockLowCycles = 8;
  localparam int doneTimeout = 12;
  localparam int releaseTimeout = 40;

  logic s_systemClock;
  logic s_pllLocked;
  logic ciStart;
  logic [ciPkg::ciIdWidth-1:0] ciN;
  logic [ciPkg::ciDataWidth-1:0] ciDataA;
  logic [ciPkg::ciDataWidth-1:0] ciDataB;
  logic ciDone;
  logic [ciPkg::ciDataWidth-1:0] ciResult;
  logic unitReset;
  logic [31:0] rngState;

  customInstructionUnit customInstructionUnit_inst (
    .s_systemClock (s_systemClock),
    .s_pllLocked   (s_pllLocked),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .ciDataB       (ciDataB),
    .ciDone        (ciDone),
    .ciResult      (ciResult),
    .unitReset     (unitReset)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #clockHalfPeriod s_systemClock = ~s_systemClock;
  end

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // the bound checker raises failSeen from its action blocks
  always @(negedge s_systemClock) begin
    if (customInstructionUnit_inst.ciUnitSva_inst.failSeen) begin
      $display("an assertion on the DUT failed");
      $display("** FAIL **");
      $fatal(1, "stopping after assertion failure");
    end
  end

  task automatic sendStart(input logic [7:0] id, input logic [31:0] dataA);
    @(posedge s_systemClock);
    #driveDelay;
    ciStart = 1'b1;
    ciN = id;
    ciDataA = dataA;
    ciDataB = nextRandom();
  endtask

  task automatic endStart();
    @(posedge s_systemClock);
    #driveDelay;
    ciStart = 1'b0;
  endtask

  task automatic waitForDones(input int count, input string testName);
    int seen;
    int waited;
    seen = 0;
    waited = 0;
    while (seen < count) begin
      @(negedge s_systemClock);
      if (ciDone === 1'b1) begin
        seen++;
      end
      waited++;
      if (seen < count && waited > doneTimeout) begin
        $display("%s timed out after %0d of %0d done strobes", testName, seen, count);
        $display("** FAIL **");
        $fatal(1, "done timeout");
      end
    end
  endtask

  // lock rises, a few starts land inside the stretch, then wait for release
  task automatic releaseLock(input int lowCycles);
    int waited;
    repeat (lowCycles) @(posedge s_systemClock);
    #driveDelay;
    s_pllLocked = 1'b1;
    repeat (4) begin
      sendStart(ciPkg::swapByteId, nextRandom());
    end
    endStart();
    waited = 0;
    @(negedge s_systemClock);
    while (unitReset !== 1'b0) begin
      waited++;
      if (waited > releaseTimeout) begin
        $display("unitReset never went low after s_pllLocked rose");
        $display("** FAIL **");
        $fatal(1, "release timeout");
      end
      @(negedge s_systemClock);
    end
  endtask

  initial begin
    logic [31:0] word;
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    rngState = 32'd60;

    releaseLock(lockLowCycles);

    repeat (6) begin
      sendStart(ciPkg::swapByteId, nextRandom());
      endStart();
      waitForDones(1, "swapByte");
    end

    // full-scale and black lower pixels first
    sendStart(ciPkg::grayscaleId, 32'h0000_ffff);
    endStart();
    waitForDones(1, "grayscale");
    sendStart(ciPkg::grayscaleId, 32'hffff_0000);
    endStart();
    waitForDones(1, "grayscale");
    repeat (6) begin
      sendStart(ciPkg::grayscaleId, nextRandom());
      endStart();
      waitForDones(1, "grayscale");
    end

    repeat (3) begin
      sendStart(ciPkg::cycleCountId, nextRandom());
      sendStart(ciPkg::cycleCountId, nextRandom());
      endStart();
      waitForDones(2, "cycleCount");
    end

    // nothing should answer unclaimed numbers
    sendStart(8'd7, nextRandom());
    endStart();
    repeat (6) @(posedge s_systemClock);
    repeat (4) begin
      word = nextRandom();
      sendStart({1'b1, word[6:0]}, nextRandom());
    end
    endStart();
    repeat (6) @(posedge s_systemClock);

    // swap and grayscale interleaved with three in flight
    repeat (5) begin
      repeat (3) begin
        word = nextRandom();
        sendStart(word[0] ? ciPkg::swapByteId : ciPkg::grayscaleId, nextRandom());
      end
      endStart();
      waitForDones(3, "mixedBurst");
    end

    // lock drops mid-run
    @(posedge s_systemClock);
    #driveDelay;
    s_pllLocked = 1'b0;
    releaseLock(3);
    sendStart(ciPkg::swapByteId, nextRandom());
    endStart();
    waitForDones(1, "swapAfterRelock");

    @(negedge s_systemClock);
    if (customInstructionUnit_inst.ciUnitSva_inst.failSeen) begin
      $display("an assertion on the DUT failed near the end of the run");
      $display("** FAIL **");
      $fatal(1, "stopping after assertion failure");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== build.f ====
verilog/ciPkg.sv
verilog/ciRequestIf.sv
verilog/ciRequestStage.sv
verilog/pixelFormatIse.sv
verilog/cycleCounterIse.sv
verilog/ciResultMerge.sv
verilog/customInstructionUnit.sv
verif/ciUnit_sva.sv
verif/ciUnitTb.sv

// ==== Bender.yml ====
package:
  name: customInstructionUnit

sources:
  - verilog/ciPkg.sv
  - verilog/ciRequestIf.sv
  - verilog/ciRequestStage.sv
  - verilog/pixelFormatIse.sv
  - verilog/cycleCounterIse.sv
  - verilog/ciResultMerge.sv
  - verilog/customInstructionUnit.sv
  - target: test
    files:
      - verif/ciUnit_sva.sv
      - verif/ciUnitTb.sv
